//--- floor_logic_control_unit.f
+incdir+logic
logic/floor_pkg.sv
logic/request_latch.sv
logic/request_stack.sv
logic/car_dispatch.sv
logic/floor_logic_control_unit.sv
verification/clock_gen.sv
verification/floor_logic_tb.sv

//--- logic/car_dispatch.sv
// Car dispatch and door permits

`timescale 1ns/10ps
`default_nettype none

`include "floor_defines.svh"

module car_dispatch (
    input  wire logic                      clock,
    input  wire logic                      reset_n,
    input  wire floor_pkg::car_status_t    car_status,
    input  wire floor_pkg::floor_request_t top,
    input  wire floor_pkg::mode_t          mode,
    input  wire logic                      door_open_btn,
    input  wire logic                      door_close_btn,
    output floor_pkg::dispatch_t           dispatch,
    output floor_pkg::floor_request_t      arrival,
    output logic                           pop,
    output logic                           door_open_allowed,
    output logic                           door_close_allowed
);

    logic               stopped;
    logic               stopped_powered;
    logic               direction_up;
    floor_pkg::floor_t  selector;

    ////////////////////////////////////////////////////////////////////////////
    // State decode
    ////////////////////////////////////////////////////////////////////////////

    // Anything above the last stop code is travel or emergency
    assign stopped = (car_status.state <= `STATE_WIDTH'(`LAST_STOP_STATE));

    assign stopped_powered = stopped && mode.powered;

    ////////////////////////////////////////////////////////////////////////////
    // Target selection
    ////////////////////////////////////////////////////////////////////////////

    // Idle car points at where it already is
    assign selector = top.valid ? top.floor : car_status.floor;

    assign dispatch.selector  = selector;
    assign dispatch.activate  = stopped && !mode.halted && (selector != car_status.floor);
    assign dispatch.direction = direction_up;

    // Direction is held between trips
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            direction_up <= 1'b1;
        end else if (dispatch.activate) begin
            direction_up <= (selector > car_status.floor);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Retirement and doors
    ////////////////////////////////////////////////////////////////////////////

    // Lights at the car floor clear every cycle it stands there
    assign arrival.valid = stopped_powered;
    assign arrival.floor = car_status.floor;

    // Retire the top once the car has reached it
    assign pop = stopped && !mode.halted && top.valid && (top.floor == car_status.floor);

    // Doors only move with the car at rest and power on
    assign door_open_allowed  = stopped_powered && door_open_btn;
    assign door_close_allowed = stopped_powered && door_close_btn;

endmodule

`default_nettype wire

//--- logic/floor_defines.svh
// Floor controller sizing constants

`ifndef FLOOR_DEFINES_SVH
`define FLOOR_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Building and car geometry
////////////////////////////////////////////////////////////////////////////

// Floors served, numbered 0 for floor 1
`define FLOOR_COUNT 11

// Bits needed for a floor number
`define FLOOR_WIDTH 4

// Motion controller state code width
`define STATE_WIDTH 6

// Codes 0 to 10 mean stopped at floors 1 to 11
`define LAST_STOP_STATE 10

////////////////////////////////////////////////////////////////////////////
// Request stack
////////////////////////////////////////////////////////////////////////////

// One slot per floor is enough since a lit button blocks repeats
`define STACK_DEPTH 11

// Entry count runs 0 to STACK_DEPTH
`define STACK_PTR_WIDTH 4

`endif

//--- logic/floor_logic_control_unit.sv
// Elevator floor request controller

`timescale 1ns/10ps
`default_nettype none

module floor_logic_control_unit (
    input  wire logic                    clock,
    input  wire logic                    reset_n,
    input  wire floor_pkg::button_vec_t  floor_call_buttons,
    input  wire floor_pkg::button_vec_t  panel_buttons,
    input  wire logic                    door_open_btn,
    input  wire logic                    door_close_btn,
    input  wire logic                    emergency_btn,
    input  wire logic                    power_switch,
    input  wire floor_pkg::car_status_t  car_status,
    output floor_pkg::dispatch_t         dispatch,
    output floor_pkg::button_vec_t       call_button_lights,
    output floor_pkg::button_vec_t       panel_button_lights,
    output logic                         door_open_allowed,
    output logic                         door_close_allowed
);

    floor_pkg::floor_request_t  push;
    floor_pkg::floor_request_t  top;
    floor_pkg::floor_request_t  arrival;
    floor_pkg::mode_t           mode;
    logic                       full;
    logic                       pop;

    // Buttons in, one request per cycle out
    request_latch u_request_latch (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .car_floor           (car_status.floor),
        .full                (full),
        .arrival             (arrival),
        .push                (push),
        .mode                (mode),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    request_stack u_request_stack (
        .clock   (clock),
        .reset_n (reset_n),
        .push    (push),
        .pop     (pop),
        .mode    (mode),
        .top     (top),
        .full    (full)
    );

    // Most recent request drives the car
    car_dispatch u_car_dispatch (
        .clock              (clock),
        .reset_n            (reset_n),
        .car_status         (car_status),
        .top                (top),
        .mode               (mode),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .dispatch           (dispatch),
        .arrival            (arrival),
        .pop                (pop),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

//--- logic/floor_pkg.sv
// Floor controller types

`default_nettype none

`include "floor_defines.svh"

package floor_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////////////////////////////////////////

    // Floor number, 0 is floor 1
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, bit 0 is floor 1
    typedef logic [`FLOOR_COUNT-1:0] button_vec_t;

    ////////////////////////////////////////////////////////////////////////////
    // Grouped signals
    ////////////////////////////////////////////////////////////////////////////

    // Report from the motion controller
    typedef struct packed {
        floor_t                   floor;
        logic [`STATE_WIDTH-1:0]  state;
    } car_status_t;

    // Floor number qualified by a valid bit
    typedef struct packed {
        logic    valid;
        floor_t  floor;
    } floor_request_t;

    // Halted covers power off as well as the emergency button
    typedef struct packed {
        logic  powered;
        logic  halted;
    } mode_t;

    // Command to the motion controller, direction 1 is up
    typedef struct packed {
        floor_t  selector;
        logic    direction;
        logic    activate;
    } dispatch_t;

endpackage

`default_nettype wire

//--- logic/request_latch.sv
// Button request qualifier

`timescale 1ns/10ps
`default_nettype none

`include "floor_defines.svh"

module request_latch (
    input  wire logic                     clock,
    input  wire logic                     reset_n,
    input  wire floor_pkg::button_vec_t   floor_call_buttons,
    input  wire floor_pkg::button_vec_t   panel_buttons,
    input  wire logic                     emergency_btn,
    input  wire logic                     power_switch,
    input  wire floor_pkg::floor_t        car_floor,
    input  wire logic                     full,
    input  wire floor_pkg::floor_request_t arrival,
    output floor_pkg::floor_request_t     push,
    output floor_pkg::mode_t              mode,
    output floor_pkg::button_vec_t        call_button_lights,
    output floor_pkg::button_vec_t        panel_button_lights
);

    floor_pkg::button_vec_t  car_mask;
    floor_pkg::button_vec_t  arrival_mask;
    floor_pkg::button_vec_t  panel_eligible;
    floor_pkg::button_vec_t  call_eligible;
    floor_pkg::button_vec_t  panel_set;
    floor_pkg::button_vec_t  call_set;
    logic                    accept;
    logic                    pick_panel;

    function automatic floor_pkg::button_vec_t floor_onehot(input floor_pkg::floor_t f);
        floor_pkg::button_vec_t vec;
        vec = '0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            vec[i] = (f == floor_pkg::floor_t'(i));
        end
        return vec;
    endfunction

    // Mode tracks the switches with no delay
    assign mode.powered = power_switch;
    assign mode.halted  = !power_switch || emergency_btn;

    ////////////////////////////////////////////////////////////////////////////
    // Press qualification
    ////////////////////////////////////////////////////////////////////////////

    assign accept       = !mode.halted && !full;
    assign car_mask     = floor_onehot(car_floor);
    assign arrival_mask = arrival.valid ? floor_onehot(arrival.floor) : '0;

    // Lit buttons and the floor the car sits at take no new request
    assign panel_eligible = panel_buttons & ~panel_button_lights & ~car_mask
                            & {`FLOOR_COUNT{accept}};
    assign call_eligible  = floor_call_buttons & ~call_button_lights & ~car_mask
                            & {`FLOOR_COUNT{accept}};

    // Scan from the top so the lowest floor is the last write
    always_comb begin
        push       = '0;
        pick_panel = 1'b0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (panel_eligible[i]) begin
                push.valid = 1'b1;
                push.floor = floor_pkg::floor_t'(i);
                pick_panel = 1'b1;
            end
        end
        // Hall calls only get a turn when no panel press is waiting
        if (!pick_panel) begin
            for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
                if (call_eligible[i]) begin
                    push.valid = 1'b1;
                    push.floor = floor_pkg::floor_t'(i);
                end
            end
        end
    end

    assign panel_set = (push.valid && pick_panel) ? floor_onehot(push.floor) : '0;
    assign call_set  = (push.valid && !pick_panel) ? floor_onehot(push.floor) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Button lights
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else if (mode.halted) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else begin
            // Arrival floor never overlaps a new press, so order is free
            panel_button_lights <= (panel_button_lights & ~arrival_mask) | panel_set;
            call_button_lights  <= (call_button_lights & ~arrival_mask) | call_set;
        end
    end

endmodule

`default_nettype wire

//--- logic/request_stack.sv
// Floor request LIFO

`timescale 1ns/10ps
`default_nettype none

`include "floor_defines.svh"

module request_stack (
    input  wire logic                      clock,
    input  wire logic                      reset_n,
    input  wire floor_pkg::floor_request_t push,
    input  wire logic                      pop,
    input  wire floor_pkg::mode_t          mode,
    output floor_pkg::floor_request_t      top,
    output logic                           full
);

    floor_pkg::floor_t               entries [`STACK_DEPTH];
    logic [`STACK_PTR_WIDTH-1:0]     count;
    logic [`STACK_PTR_WIDTH-1:0]     top_index;
    logic [`STACK_PTR_WIDTH-1:0]     write_index;
    logic                            write_en;
    logic                            do_pop;

    ////////////////////////////////////////////////////////////////////////////
    // Status and top of stack
    ////////////////////////////////////////////////////////////////////////////

    assign full      = (count == `STACK_PTR_WIDTH'(`STACK_DEPTH));
    assign top_index = count - 1'b1;

    assign top.valid = (count != '0);
    assign top.floor = top.valid ? entries[top_index] : '0;

    // Popping an empty stack is a no-op
    assign do_pop = pop && top.valid && !mode.halted;

    // With a pop in the same cycle the push lands on the old top
    assign write_en    = push.valid && !mode.halted && (do_pop || !full);
    assign write_index = do_pop ? top_index : count;

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (write_en) begin
            entries[write_index] <= push.floor;
        end
    end

    // Entry count, which is also the next free slot
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (mode.halted) begin
            // Flush, stale entries are simply left behind
            count <= '0;
        end else if (write_en && !do_pop) begin
            count <= count + 1'b1;
        end else if (do_pop && !write_en) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the floor controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module floor_logic_tb \
    -f floor_logic_control_unit.f \
    -o floor_logic_sim > build.log 2>&1 \
    && ./obj_dir/floor_logic_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "^TEST PASSED$" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- verification/clock_gen.sv
// Testbench clock and reset

`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock = ~clock;
        end
    end

    // Release on a falling edge, well away from the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/floor_logic_tb.sv
// Floor controller testbench

`timescale 1ns/10ps
`default_nettype none

`include "floor_defines.svh"

module floor_logic_tb;

    // Cycle budget of each test
    localparam int RESET_CYCLES  = 10;
    localparam int PRESS_CYCLES  = 50;
    localparam int ARRIVE_CYCLES = 100;
    localparam int FULL_CYCLES   = 30;
    localparam int HALT_CYCLES   = 40;
    localparam int DOOR_CYCLES   = 50;
    localparam int CYCLE_LIMIT   = 2 * (RESET_CYCLES + PRESS_CYCLES + ARRIVE_CYCLES
                                        + FULL_CYCLES + HALT_CYCLES + DOOR_CYCLES);

    logic                    clock;
    logic                    reset_n;
    floor_pkg::button_vec_t  floor_call_buttons;
    floor_pkg::button_vec_t  panel_buttons;
    logic                    door_open_btn;
    logic                    door_close_btn;
    logic                    emergency_btn;
    logic                    power_switch;
    floor_pkg::car_status_t  car_status;
    floor_pkg::dispatch_t    dispatch;
    floor_pkg::button_vec_t  call_button_lights;
    floor_pkg::button_vec_t  panel_button_lights;
    logic                    door_open_allowed;
    logic                    door_close_allowed;

    // Reference model state with the stack top as the last entry
    floor_pkg::floor_t       model_stack [$];
    floor_pkg::button_vec_t  model_call_lights;
    floor_pkg::button_vec_t  model_panel_lights;
    logic                    model_up;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    int test_errors = 0;
    int cycle_count = 0;

    clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_logic_control_unit UUT (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .door_open_btn       (door_open_btn),
        .door_close_btn      (door_close_btn),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .car_status          (car_status),
        .dispatch            (dispatch),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic car_stopped();
        return car_status.state <= `STATE_WIDTH'(`LAST_STOP_STATE);
    endfunction

    function automatic logic car_halted();
        return !power_switch || emergency_btn;
    endfunction

    // Expected command to the motion controller
    function automatic floor_pkg::dispatch_t expected_dispatch();
        floor_pkg::dispatch_t cmd;
        cmd.selector  = (model_stack.size() > 0) ? model_stack[model_stack.size() - 1]
                                                 : car_status.floor;
        cmd.activate  = car_stopped() && !car_halted() && (cmd.selector != car_status.floor);
        cmd.direction = model_up;
        return cmd;
    endfunction

    // Panel presses beat hall calls and the lowest floor wins in each group
    function automatic logic pick_press(output floor_pkg::floor_t press_floor,
                                        output logic from_panel);
        press_floor = '0;
        from_panel  = 1'b0;
        if (car_halted() || model_stack.size() >= `STACK_DEPTH) begin
            return 1'b0;
        end
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (panel_buttons[i] && !model_panel_lights[i]
                && car_status.floor != floor_pkg::floor_t'(i)) begin
                press_floor = floor_pkg::floor_t'(i);
                from_panel  = 1'b1;
                return 1'b1;
            end
        end
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (floor_call_buttons[i] && !model_call_lights[i]
                && car_status.floor != floor_pkg::floor_t'(i)) begin
                press_floor = floor_pkg::floor_t'(i);
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic reset_model();
        model_stack.delete();
        model_call_lights  = '0;
        model_panel_lights = '0;
        model_up           = 1'b1;
    endtask

    // One clock edge of the request rules
    task automatic advance_model();
        floor_pkg::dispatch_t  cmd;
        floor_pkg::floor_t     press_floor;
        logic                  from_panel;
        logic                  pressed;
        cmd     = expected_dispatch();
        pressed = pick_press(press_floor, from_panel);
        if (cmd.activate) begin
            model_up = (cmd.selector > car_status.floor);
        end
        if (car_halted()) begin
            reset_model();
            model_up = cmd.direction;
        end else begin
            if (car_stopped() && model_stack.size() > 0
                && model_stack[model_stack.size() - 1] == car_status.floor) begin
                void'(model_stack.pop_back());
            end
            if (pressed) begin
                model_stack.push_back(press_floor);
            end
            if (car_stopped()) begin
                model_call_lights[car_status.floor]  = 1'b0;
                model_panel_lights[car_status.floor] = 1'b0;
            end
            if (pressed && from_panel) begin
                model_panel_lights[press_floor] = 1'b1;
            end else if (pressed) begin
                model_call_lights[press_floor] = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("ERROR: %s is %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic compare_outputs();
        floor_pkg::dispatch_t  cmd;
        logic                  doors_live;
        cmd        = expected_dispatch();
        doors_live = car_stopped() && power_switch;
        check_value("dispatch.selector", 32'(dispatch.selector), 32'(cmd.selector));
        check_value("dispatch.direction", 32'(dispatch.direction), 32'(cmd.direction));
        check_value("dispatch.activate", 32'(dispatch.activate), 32'(cmd.activate));
        check_value("call_button_lights", 32'(call_button_lights), 32'(model_call_lights));
        check_value("panel_button_lights", 32'(panel_button_lights), 32'(model_panel_lights));
        check_value("door_open_allowed", 32'(door_open_allowed),
                    32'(doors_live && door_open_btn));
        check_value("door_close_allowed", 32'(door_close_allowed),
                    32'(doors_live && door_close_btn));
    endtask

    // Outputs are read before the edge updates them
    always @(posedge clock) begin
        if (!reset_n) begin
            reset_model();
        end else begin
            compare_outputs();
            advance_model();
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Run went past %0d cycles without finishing the tests", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic press_buttons(input floor_pkg::button_vec_t panel,
                                 input floor_pkg::button_vec_t call, input int cycles);
        @(negedge clock);
        panel_buttons      = panel;
        floor_call_buttons = call;
        repeat (cycles) @(negedge clock);
        panel_buttons      = '0;
        floor_call_buttons = '0;
    endtask

    task automatic place_car(input floor_pkg::floor_t target);
        @(negedge clock);
        car_status.floor = target;
        car_status.state = `STATE_WIDTH'(target);
    endtask

    // A short trip through travel codes and a stop with time to retire
    task automatic travel_to(input floor_pkg::floor_t target);
        @(negedge clock);
        car_status.state = `STATE_WIDTH'($urandom_range(63, 11));
        repeat (2) @(negedge clock);
        car_status.floor = target;
        car_status.state = `STATE_WIDTH'(target);
        repeat (2) @(negedge clock);
    endtask

    task automatic check_flushed();
        check_value("call_button_lights", 32'(call_button_lights), 32'h0);
        check_value("panel_button_lights", 32'(panel_button_lights), 32'h0);
        check_value("dispatch.activate", 32'(dispatch.activate), 32'h0);
        check_value("dispatch.selector", 32'(dispatch.selector), 32'(car_status.floor));
    endtask

    task automatic begin_test();
        test_count++;
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        $display("Test %0d %s finished with %0d errors", test_count, name,
                 error_count - test_errors);
    endtask

    initial begin
        floor_pkg::floor_t target;
        void'($urandom(32'hda84_bb94));
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        car_status         = '0;

        begin_test();
        wait (reset_n === 1'b1);
        repeat (3) @(negedge clock);
        check_flushed();
        check_value("dispatch.direction", 32'(dispatch.direction), 32'h1);
        check_value("door_open_allowed", 32'(door_open_allowed), 32'h0);
        check_value("door_close_allowed", 32'(door_close_allowed), 32'h0);
        end_test("reset");

        begin_test();
        place_car(4);
        press_buttons(11'h080, '0, 1);
        check_value("panel_button_lights[7]", 32'(panel_button_lights[7]), 32'h1);
        check_value("dispatch.selector", 32'(dispatch.selector), 32'h7);
        // Current floor takes no request
        press_buttons(11'h010, '0, 1);
        check_value("panel_button_lights[4]", 32'(panel_button_lights[4]), 32'h0);
        press_buttons('0, 11'h004, 1);
        press_buttons(11'h202, 11'h001, 3);
        repeat (12) begin
            press_buttons(floor_pkg::button_vec_t'($urandom & $urandom & $urandom),
                          floor_pkg::button_vec_t'($urandom & $urandom & $urandom), 1);
        end
        end_test("button presses");

        begin_test();
        for (int n = 0; n < 16 && model_stack.size() > 0; n++) begin
            target = model_stack[model_stack.size() - 1];
            travel_to(target);
            check_value("panel_button_lights[target]", 32'(panel_button_lights[target]), 32'h0);
            check_value("call_button_lights[target]", 32'(call_button_lights[target]), 32'h0);
        end
        check_flushed();
        end_test("arrivals");

        begin_test();
        place_car(0);
        press_buttons(11'h7fe, '0, 10);
        press_buttons('0, 11'h020, 1);
        press_buttons('0, 11'h040, 2);
        check_value("call_button_lights[6]", 32'(call_button_lights[6]), 32'h0);
        check_value("dispatch.selector", 32'(dispatch.selector), 32'h5);
        end_test("full stack");

        begin_test();
        @(negedge clock);
        emergency_btn = 1'b1;
        repeat (2) @(negedge clock);
        check_flushed();
        emergency_btn = 1'b0;
        press_buttons(11'h008, 11'h100, 2);
        @(negedge clock);
        power_switch = 1'b0;
        repeat (2) @(negedge clock);
        check_flushed();
        power_switch = 1'b1;
        end_test("emergency and power loss");

        begin_test();
        repeat (40) begin
            @(negedge clock);
            door_open_btn  = 1'($urandom);
            door_close_btn = 1'($urandom);
            power_switch   = ($urandom_range(7, 0) != 0);
            if ($urandom_range(1, 0) == 0) begin
                car_status.state = `STATE_WIDTH'(car_status.floor);
            end else begin
                car_status.state = `STATE_WIDTH'($urandom_range(63, 11));
            end
        end
        @(negedge clock);
        power_switch     = 1'b1;
        door_open_btn    = 1'b1;
        door_close_btn   = 1'b1;
        car_status.state = `STATE_WIDTH'(40);
        @(negedge clock);
        check_value("door_open_allowed", 32'(door_open_allowed), 32'h0);
        check_value("door_close_allowed", 32'(door_close_allowed), 32'h0);
        end_test("door permits");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
